// ==== logic/raycastPkg.sv ====
/*
  raycastPkg
  fixed-point format and ray word field layout shared by the
  wall-finding stage of the column raycaster
*/
package raycastPkg;

  localparam int FRAC_BITS      = 8;    // 8.8 fixed point
  localparam int FIX_WIDTH      = 16;   // distances and positions
  localparam int HCOUNT_WIDTH   = 9;    // screen column number
  localparam int CELL_WIDTH     = 4;    // map cell value, 0 is empty
  localparam int RAY_WORD_WIDTH = 107;

  // ray word fields, packed from the bottom up
  localparam int SIDE_Y_LSB  = 0;
  localparam int SIDE_X_LSB  = SIDE_Y_LSB + FIX_WIDTH;
  localparam int POS_Y_LSB   = SIDE_X_LSB + FIX_WIDTH;
  localparam int POS_X_LSB   = POS_Y_LSB + FIX_WIDTH;
  localparam int DELTA_Y_LSB = POS_X_LSB + FIX_WIDTH;
  localparam int DELTA_X_LSB = DELTA_Y_LSB + FIX_WIDTH;
  localparam int STEP_Y_BIT  = DELTA_X_LSB + FIX_WIDTH;  // 1 means +1, 0 means -1
  localparam int STEP_X_BIT  = STEP_Y_BIT + 1;
  localparam int HCOUNT_LSB  = STEP_X_BIT + 1;           // top field, ends at bit 106

endpackage

// ==== logic/rayIf.sv ====
/*
  rayIf / mapIf
  rayIf carries the decoded ray from the intake to the DDA stepper,
  mapIf is the stepper's single-request read port into the map memory
*/
`timescale 1ns/10ps

interface rayIf;
  import raycastPkg::*;

  logic [HCOUNT_WIDTH-1:0] hcount;
  logic                    stepX;        // 1 steps +1, 0 steps -1
  logic                    stepY;
  logic [FIX_WIDTH-1:0]    deltaDistX;   // 8.8
  logic [FIX_WIDTH-1:0]    deltaDistY;
  logic [FIX_WIDTH-1:0]    posX;         // 8.8, integer part is the start cell
  logic [FIX_WIDTH-1:0]    posY;
  logic [FIX_WIDTH-1:0]    sideDistX;    // distance to first x side
  logic [FIX_WIDTH-1:0]    sideDistY;
  logic                    rayLoad;      // one cycle, fields are fresh
  logic                    stepperBusy;  // back from the stepper

  modport source (output hcount, stepX, stepY, deltaDistX, deltaDistY, posX, posY,
                  sideDistX, sideDistY, rayLoad, input stepperBusy);
  modport sink (input hcount, stepX, stepY, deltaDistX, deltaDistY, posX, posY,
                sideDistX, sideDistY, rayLoad, output stepperBusy);
endinterface

interface mapIf #(parameter int MAP_SIZE = 24);
  import raycastPkg::*;

  logic [$clog2(MAP_SIZE*MAP_SIZE)-1:0] cellAddr;  // x + y*MAP_SIZE
  logic                                 cellRequest; // held until cellValid
  logic [CELL_WIDTH-1:0]                cellData;
  logic                                 cellValid;   // one cycle per request

  modport client (output cellAddr, cellRequest, input cellData, cellValid);
  modport server (input cellAddr, cellRequest, output cellData, cellValid);
endinterface

// ==== logic/rayIntake.sv ====
/*
  rayIntake
  latches the packed ray word on its strobe while the stepper is idle,
  pulses rayLoad and slices the held word into the ray fields
*/
`timescale 1ns/10ps

module rayIntake (
  input  logic                                pixel_clk_in,
  input  logic                                rst_in,
  input  logic [raycastPkg::RAY_WORD_WIDTH-1:0] rayWord,
  input  logic                                rayValid,
  output logic                                rayBusy,
  rayIf.source                                ray
);
  import raycastPkg::*;

  logic [RAY_WORD_WIDTH-1:0] wordReg;  // stays put until the next accepted ray
  logic                      accept;

  // busy covers the load cycle before the stepper raises its own level
  assign rayBusy = ray.stepperBusy | ray.rayLoad;
  assign accept  = rayValid & ~rayBusy;  // strobes while busy are dropped

  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      ray.rayLoad <= 1'b0;
    end else begin
      ray.rayLoad <= accept;
    end
  end

  always_ff @(posedge pixel_clk_in) begin
    if (accept) begin
      wordReg <= rayWord;
    end
  end

  assign ray.hcount     = wordReg[HCOUNT_LSB +: HCOUNT_WIDTH];
  assign ray.stepX      = wordReg[STEP_X_BIT];
  assign ray.stepY      = wordReg[STEP_Y_BIT];
  assign ray.deltaDistX = wordReg[DELTA_X_LSB +: FIX_WIDTH];
  assign ray.deltaDistY = wordReg[DELTA_Y_LSB +: FIX_WIDTH];
  assign ray.posX       = wordReg[POS_X_LSB +: FIX_WIDTH];
  assign ray.posY       = wordReg[POS_Y_LSB +: FIX_WIDTH];
  assign ray.sideDistX  = wordReg[SIDE_X_LSB +: FIX_WIDTH];
  assign ray.sideDistY  = wordReg[SIDE_Y_LSB +: FIX_WIDTH];

endmodule

// ==== logic/mapRam.sv ====
/*
  mapRam
  MAP_SIZE x MAP_SIZE cell memory, written from the top-level port,
  read by the stepper with one-cycle latency per request
*/
`timescale 1ns/10ps

module mapRam #(
  parameter int MAP_SIZE = 24
) (
  input  logic                                 pixel_clk_in,
  input  logic                                 rst_in,
  input  logic                                 mapWrEn,
  input  logic [$clog2(MAP_SIZE*MAP_SIZE)-1:0] mapWrAddr,
  input  logic [raycastPkg::CELL_WIDTH-1:0]    mapWrData,
  mapIf.server                                 map
);
  import raycastPkg::*;

  localparam int CELLS = MAP_SIZE * MAP_SIZE;

  logic [CELL_WIDTH-1:0] cells [CELLS];
  logic                  served;      // request already answered
  logic                  newRequest;

  // only the first cycle of a held request gets an answer
  assign newRequest = map.cellRequest & ~served;

  always_ff @(posedge pixel_clk_in) begin
    if (mapWrEn) begin
      cells[mapWrAddr] <= mapWrData;
    end
    if (newRequest) begin
      map.cellData <= cells[map.cellAddr];
    end
  end

  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      served        <= 1'b0;
      map.cellValid <= 1'b0;
    end else begin
      served        <= map.cellRequest;  // clears once the stepper drops it
      map.cellValid <= newRequest;
    end
  end

endmodule

// ==== logic/fixedDivider.sv ====
/*
  fixedDivider
  unsigned 8.8 restoring divider, numerator shifted up by FRAC_BITS,
  one quotient bit per cycle, divDone 17 cycles after divStart.
  a quotient that does not fit, zero divisor included, saturates
*/
`timescale 1ns/10ps

module fixedDivider (
  input  logic                           pixel_clk_in,
  input  logic                           rst_in,
  input  logic                           divStart,
  input  logic [raycastPkg::FIX_WIDTH-1:0] numerator,
  input  logic [raycastPkg::FIX_WIDTH-1:0] denominator,
  output logic [raycastPkg::FIX_WIDTH-1:0] quotient,
  output logic                           divDone
);
  import raycastPkg::*;

  localparam int DIV_ITER = FIX_WIDTH;  // top FRAC_BITS quotient bits are known zero
  localparam int CNT_W    = $clog2(DIV_ITER + 1);

  logic                 running;
  logic [CNT_W-1:0]     iterCount;
  logic                 lastIter;
  logic [FIX_WIDTH-1:0] divisor;
  logic [FIX_WIDTH-1:0] rem;       // partial remainder, always below divisor
  logic [FIX_WIDTH-1:0] shiftQ;    // dividend bits out, quotient bits in
  logic                 saturate;
  logic                 overflow;
  logic [FIX_WIDTH:0]   trial;
  logic                 fits;
  logic [FIX_WIDTH-1:0] nextRem;
  logic [FIX_WIDTH-1:0] nextQ;

  // quotient >= 2^16 exactly when num*2^8 >= den*2^16, true for den == 0
  assign overflow = {{FRAC_BITS{1'b0}}, numerator} >= {denominator, {FRAC_BITS{1'b0}}};

  assign trial    = {rem, shiftQ[FIX_WIDTH-1]};  // bring down next dividend bit
  assign fits     = trial >= {1'b0, divisor};
  assign nextRem  = fits ? FIX_WIDTH'(trial - {1'b0, divisor}) : FIX_WIDTH'(trial);
  assign nextQ    = {shiftQ[FIX_WIDTH-2:0], fits};
  assign lastIter = running & (iterCount == CNT_W'(DIV_ITER - 1));

  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      running   <= 1'b0;
      iterCount <= '0;
      divDone   <= 1'b0;
    end else begin
      divDone <= lastIter;
      if (divStart) begin
        running   <= 1'b1;
        iterCount <= '0;
      end else if (running) begin
        iterCount <= iterCount + 1'b1;
        if (lastIter) running <= 1'b0;
      end
    end
  end

  always_ff @(posedge pixel_clk_in) begin
    if (divStart) begin
      divisor  <= denominator;
      rem      <= FIX_WIDTH'(numerator[FIX_WIDTH-1:FIX_WIDTH-FRAC_BITS]);
      shiftQ   <= {numerator[FIX_WIDTH-FRAC_BITS-1:0], {FRAC_BITS{1'b0}}};
      saturate <= overflow;
    end else if (running) begin
      rem    <= nextRem;
      shiftQ <= nextQ;
      if (lastIter) quotient <= saturate ? '1 : nextQ;
    end
  end

endmodule

// ==== logic/ddaStepper.sv ====
/*
  ddaStepper
  walks the map grid one DDA step at a time from the ray's start cell,
  reads each new cell, and on the first non-zero cell divides the
  screen height by the perpendicular distance. the result is handed
  to columnResult and the stepper stays busy until it has been taken
*/
`timescale 1ns/10ps

module ddaStepper #(
  parameter int SCREEN_HEIGHT = 180,
  parameter int MAP_SIZE      = 24
) (
  input  logic                              pixel_clk_in,
  input  logic                              rst_in,
  rayIf.sink                                ray,
  mapIf.client                              map,
  output logic                              divStart,
  output logic [raycastPkg::FIX_WIDTH-1:0]    divNumerator,
  output logic [raycastPkg::FIX_WIDTH-1:0]    divDenominator,
  input  logic                              divDone,
  input  logic [raycastPkg::FIX_WIDTH-1:0]    quotient,
  input  logic                              resultFree,
  output logic                              resultLoad,
  output logic [raycastPkg::HCOUNT_WIDTH-1:0] resultHcount,
  output logic [raycastPkg::FIX_WIDTH-1:0]    resultQuotient,
  output logic                              wallSide,
  output logic [raycastPkg::CELL_WIDTH-1:0]   cellValue
);
  import raycastPkg::*;

  localparam int COORD_W = $clog2(MAP_SIZE);
  localparam int ADDR_W  = $clog2(MAP_SIZE * MAP_SIZE);

  localparam logic [2:0] IDLE = 3'd0, SETUP = 3'd1, X_STEP = 3'd2, Y_STEP = 3'd3,
                         WALL_CHECK = 3'd4, DIV_WAIT = 3'd5, HAND_OFF = 3'd6;

  logic [2:0]           state;
  logic                 handed;     // result loaded, waiting for it to leave
  logic [FIX_WIDTH-1:0] sideX;
  logic [FIX_WIDTH-1:0] sideY;
  logic [COORD_W-1:0]   mapX;
  logic [COORD_W-1:0]   mapY;
  logic [COORD_W-1:0]   nextX;
  logic [COORD_W-1:0]   nextY;

  function automatic logic [ADDR_W-1:0] cellAddrOf(input logic [COORD_W-1:0] x,
                                                   input logic [COORD_W-1:0] y);
    cellAddrOf = ADDR_W'(x) + ADDR_W'(y) * ADDR_W'(MAP_SIZE);  // row-major map
  endfunction

  assign nextX = ray.stepX ? mapX + 1'b1 : mapX - 1'b1;
  assign nextY = ray.stepY ? mapY + 1'b1 : mapY - 1'b1;

  assign ray.stepperBusy = (state != IDLE);
  assign divNumerator    = FIX_WIDTH'(SCREEN_HEIGHT << FRAC_BITS);  // height in 8.8
  assign resultHcount    = ray.hcount;  // intake holds the word while busy

  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      state           <= IDLE;
      handed          <= 1'b0;
      map.cellRequest <= 1'b0;
      divStart        <= 1'b0;
      resultLoad      <= 1'b0;
    end else begin
      divStart   <= 1'b0;  // both are single-cycle strobes
      resultLoad <= 1'b0;
      case (state)
        IDLE: begin
          handed <= 1'b0;
          if (ray.rayLoad) state <= SETUP;
        end
        SETUP: begin
          sideX <= ray.sideDistX;
          sideY <= ray.sideDistY;
          mapX  <= COORD_W'(ray.posX[FIX_WIDTH-1:FRAC_BITS]);  // start cell
          mapY  <= COORD_W'(ray.posY[FIX_WIDTH-1:FRAC_BITS]);
          state <= (ray.sideDistX < ray.sideDistY) ? X_STEP : Y_STEP;  // tie goes y
        end
        X_STEP: begin
          sideX           <= sideX + ray.deltaDistX;
          mapX            <= nextX;
          wallSide        <= 1'b0;
          map.cellAddr    <= cellAddrOf(nextX, mapY);
          map.cellRequest <= 1'b1;
          state           <= WALL_CHECK;
        end
        Y_STEP: begin
          sideY           <= sideY + ray.deltaDistY;
          mapY            <= nextY;
          wallSide        <= 1'b1;
          map.cellAddr    <= cellAddrOf(mapX, nextY);
          map.cellRequest <= 1'b1;
          state           <= WALL_CHECK;
        end
        WALL_CHECK: begin
          if (map.cellValid) begin
            map.cellRequest <= 1'b0;
            cellValue       <= map.cellData;
            if (map.cellData != '0) begin
              // perpendicular distance, undo the last step's delta
              divDenominator <= wallSide ? sideY - ray.deltaDistY : sideX - ray.deltaDistX;
              divStart       <= 1'b1;
              state          <= DIV_WAIT;
            end else begin
              state <= (sideX < sideY) ? X_STEP : Y_STEP;
            end
          end
        end
        DIV_WAIT: begin
          if (divDone) begin
            resultQuotient <= quotient;
            state          <= HAND_OFF;
          end
        end
        HAND_OFF: begin
          if (!handed && resultFree) begin
            resultLoad <= 1'b1;
            handed     <= 1'b1;
          end else if (handed && !resultLoad && resultFree) begin
            state <= IDLE;  // column has left through columnReady
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

// ==== logic/columnResult.sv ====
/*
  columnResult
  turns the 8.8 quotient into an integer line height clamped to the
  screen, holds the column and releases it while columnReady is high
*/
`timescale 1ns/10ps

module columnResult #(
  parameter int SCREEN_HEIGHT = 180
) (
  input  logic                                 pixel_clk_in,
  input  logic                                 rst_in,
  input  logic                                 resultLoad,
  input  logic [raycastPkg::HCOUNT_WIDTH-1:0]  resultHcount,
  input  logic [raycastPkg::FIX_WIDTH-1:0]     resultQuotient,
  input  logic                                 wallSide,
  input  logic [raycastPkg::CELL_WIDTH-1:0]    cellValue,
  output logic                                 resultFree,
  input  logic                                 columnReady,
  output logic                                 columnValid,
  output logic [raycastPkg::HCOUNT_WIDTH-1:0]  hcountOut,
  output logic [$clog2(SCREEN_HEIGHT+1)-1:0]   lineHeight,
  output logic                                 wallSideOut,
  output logic [raycastPkg::CELL_WIDTH-1:0]    cellOut
);
  import raycastPkg::*;

  localparam int LH_WIDTH = $clog2(SCREEN_HEIGHT + 1);

  logic                           held;     // a column waits for the FIFO
  logic [FIX_WIDTH-FRAC_BITS-1:0] intPart;  // floor of the quotient

  assign intPart     = resultQuotient[FIX_WIDTH-1:FRAC_BITS];
  assign resultFree  = ~held;
  assign columnValid = held & columnReady;  // leaves only on the ready level

  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      held <= 1'b0;
    end else if (resultLoad) begin
      held <= 1'b1;
    end else if (columnValid) begin
      held <= 1'b0;
    end
  end

  // fields stay stable after release until the next load
  always_ff @(posedge pixel_clk_in) begin
    if (resultLoad) begin
      hcountOut   <= resultHcount;
      lineHeight  <= (intPart >= SCREEN_HEIGHT) ? LH_WIDTH'(SCREEN_HEIGHT) : LH_WIDTH'(intPart);
      wallSideOut <= wallSide;
      cellOut     <= cellValue;
    end
  end

endmodule

// ==== logic/raycastCore.sv ====
/*
  raycastCore
  wall-finding stage, ray word in, one column result out per ray.
  intake -> DDA stepper with map reads -> divider -> result hold
*/
`timescale 1ns/10ps

module raycastCore #(
  parameter int SCREEN_HEIGHT = 180,
  parameter int MAP_SIZE      = 24
) (
  input  logic                                  pixel_clk_in,
  input  logic                                  rst_in,
  input  logic [raycastPkg::RAY_WORD_WIDTH-1:0] rayWord,
  input  logic                                  rayValid,
  output logic                                  rayBusy,
  input  logic                                  mapWrEn,
  input  logic [$clog2(MAP_SIZE*MAP_SIZE)-1:0]  mapWrAddr,
  input  logic [raycastPkg::CELL_WIDTH-1:0]     mapWrData,
  input  logic                                  columnReady,
  output logic                                  columnValid,
  output logic [raycastPkg::HCOUNT_WIDTH-1:0]   hcountOut,
  output logic [$clog2(SCREEN_HEIGHT+1)-1:0]    lineHeight,
  output logic                                  wallSideOut,
  output logic [raycastPkg::CELL_WIDTH-1:0]     cellOut
);
  import raycastPkg::*;

  logic                    divStart, divDone;
  logic [FIX_WIDTH-1:0]    divNumerator, divDenominator, quotient;
  logic                    resultFree, resultLoad, wallSide;
  logic [HCOUNT_WIDTH-1:0] resultHcount;
  logic [FIX_WIDTH-1:0]    resultQuotient;
  logic [CELL_WIDTH-1:0]   cellValue;

  rayIf                       ray ();
  mapIf #(.MAP_SIZE(MAP_SIZE)) map ();

  rayIntake intake (.pixel_clk_in, .rst_in, .rayWord, .rayValid, .rayBusy, .ray(ray.source));

  mapRam #(.MAP_SIZE(MAP_SIZE)) mapMem (
    .pixel_clk_in, .rst_in, .mapWrEn, .mapWrAddr, .mapWrData, .map(map.server));

  ddaStepper #(.SCREEN_HEIGHT(SCREEN_HEIGHT), .MAP_SIZE(MAP_SIZE)) stepper (
    .pixel_clk_in, .rst_in, .ray(ray.sink), .map(map.client),
    .divStart, .divNumerator, .divDenominator, .divDone, .quotient,
    .resultFree, .resultLoad, .resultHcount, .resultQuotient, .wallSide, .cellValue);

  fixedDivider divider (
    .pixel_clk_in, .rst_in, .divStart, .numerator(divNumerator),
    .denominator(divDenominator), .quotient, .divDone);

  columnResult #(.SCREEN_HEIGHT(SCREEN_HEIGHT)) result (
    .pixel_clk_in, .rst_in, .resultLoad, .resultHcount, .resultQuotient, .wallSide,
    .cellValue, .resultFree, .columnReady, .columnValid, .hcountOut, .lineHeight,
    .wallSideOut, .cellOut);

endmodule

// ==== tests/raycastCore_asserts.sv ====
/*
  raycastCoreAsserts
  concurrent checks on the column strobe, the map read request
  and the ray busy level, bound into raycastCore
*/
`timescale 1ns/10ps

module raycastCoreAsserts (
  input logic pixel_clk_in,
  input logic rst_in,
  input logic rayValid,
  input logic rayBusy,
  input logic columnValid,
  input logic cellRequest,
  input logic cellValid
);

  logic inFlight;  // ray accepted, column not yet taken

  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      inFlight <= 1'b0;
    end else if (rayValid && !rayBusy) begin
      inFlight <= 1'b1;
    end else if (columnValid) begin
      inFlight <= 1'b0;
    end
  end

  columnPulse: assert property (@(posedge pixel_clk_in) disable iff (rst_in)
    columnValid |=> !columnValid)
    else $error("columnValid held longer than one cycle");

  // request may only drop once the map has answered
  requestHeld: assert property (@(posedge pixel_clk_in) disable iff (rst_in)
    cellRequest && !cellValid |=> cellRequest)
    else $error("cellRequest dropped before cellValid");

  busyCoversRay: assert property (@(posedge pixel_clk_in) disable iff (rst_in)
    !rayBusy |-> !inFlight)
    else $error("rayBusy low while a ray is still in flight");

endmodule

bind raycastCore raycastCoreAsserts checks (
  .pixel_clk_in, .rst_in, .rayValid, .rayBusy, .columnValid,
  .cellRequest(map.cellRequest), .cellValid(map.cellValid));

// ==== tests/raycastTb.sv ====
/*
  raycastTb
  self-checking testbench for the raycaster wall-finding stage.
  builds a bordered room, applies the pillar writes and ray words from
  the stim file, and checks each column result against its record
*/
`timescale 1ns/10ps

module raycastTb;
  import raycastPkg::*;

  localparam int SCREEN_HEIGHT = 180;
  localparam int MAP_SIZE      = 24;
  localparam int ADDR_W        = $clog2(MAP_SIZE * MAP_SIZE);
  localparam int LH_W          = $clog2(SCREEN_HEIGHT + 1);
  localparam int RESULT_WAIT   = 400;  // cycle budget per ray

  logic                      pixel_clk_in;
  logic                      rst_in;
  logic [RAY_WORD_WIDTH-1:0] rayWord;
  logic                      rayValid;
  logic                      rayBusy;
  logic                      mapWrEn;
  logic [ADDR_W-1:0]         mapWrAddr;
  logic [CELL_WIDTH-1:0]     mapWrData;
  logic                      columnReady;
  logic                      columnValid;
  logic [HCOUNT_WIDTH-1:0]   hcountOut;
  logic [LH_W-1:0]           lineHeight;
  logic                      wallSideOut;
  logic [CELL_WIDTH-1:0]     cellOut;

  string lineQ [$];           // W and R records in file order
  int    rayCount       = 0;
  int    writeCount     = 0;
  int    resultCount    = 0;  // columnValid pulses seen
  int    errorCount     = 0;
  int    watchdogCycles = 0;

  raycastCore #(.SCREEN_HEIGHT(SCREEN_HEIGHT), .MAP_SIZE(MAP_SIZE)) uut (
    .pixel_clk_in, .rst_in, .rayWord, .rayValid, .rayBusy, .mapWrEn, .mapWrAddr,
    .mapWrData, .columnReady, .columnValid, .hcountOut, .lineHeight, .wallSideOut, .cellOut);

  initial begin
    pixel_clk_in = 1'b0;
    forever #50 pixel_clk_in = ~pixel_clk_in;  // 100 ns period
  end

  // count every column that leaves, sampled mid-cycle
  always @(negedge pixel_clk_in) begin
    if (!rst_in && columnValid) resultCount++;
  end

  initial begin
    wait (watchdogCycles > 0);
    repeat (watchdogCycles) @(posedge pixel_clk_in);
    $display("watchdog: run did not finish within %0d cycles", watchdogCycles);
    $display("STATUS: FAIL");
    $finish;
  end

  task automatic checkValue(input string what, input int expected, input int actual);
    if (expected != actual) begin
      $display("MISMATCH %s: expected %0d, actual %0d", what, expected, actual);
      errorCount++;
    end
  endtask

  task automatic loadStim(output bit ok);
    int    fd;
    string line;
    byte   kind;
    ok = 1'b1;
    fd = $fopen("tests/rayStim.txt", "r");
    if (fd == 0) begin
      ok = 1'b0;
    end else begin
      while ($fgets(line, fd) > 0) begin
        kind = line.getc(0);
        if (kind == "W") begin
          lineQ.push_back(line);
          writeCount++;
        end else if (kind == "R") begin
          lineQ.push_back(line);
          rayCount++;
        end else if (kind != "#" && line.len() > 1) begin
          $display("unknown stim record: %s", line);
          ok = 1'b0;
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic writeCell(input int addr, input int data);
    @(posedge pixel_clk_in);
    #10;
    mapWrEn   = 1'b1;  // left high, the next drive step clears it
    mapWrAddr = ADDR_W'(addr);
    mapWrData = CELL_WIDTH'(data);
  endtask

  // outer ring gets a value from its address, inside is empty floor
  task automatic fillRoom();
    int addr;
    int x;
    int y;
    for (addr = 0; addr < MAP_SIZE * MAP_SIZE; addr++) begin
      x = addr % MAP_SIZE;
      y = addr / MAP_SIZE;
      if (x == 0 || y == 0 || x == MAP_SIZE - 1 || y == MAP_SIZE - 1) writeCell(addr, addr % 15 + 1);
      else writeCell(addr, 0);
    end
  endtask

  task automatic applyWrite(input string line);
    int addr;
    int data;
    if ($sscanf(line, "W %d %d", addr, data) != 2) begin
      $display("map write record could not be read: %s", line);
      errorCount++;
    end else begin
      writeCell(addr, data);
    end
  endtask

  task automatic castRay(input string line, input int num);
    logic [RAY_WORD_WIDTH-1:0] word;
    int    expCol, expHeight, expSide, expCell, stallMax;
    int    stall;
    int    waited;
    int    errsBefore;
    string name;
    errsBefore = errorCount;
    name = $sformatf("ray%0d", num);
    if ($sscanf(line, "R %h %d %d %d %d %d", word, expCol, expHeight, expSide, expCell,
                stallMax) != 6) begin
      $display("%s: stim record could not be read", name);
      errorCount++;
    end else begin
      stall = (stallMax + 1) / 2 + int'($urandom % (stallMax / 2 + 1));  // at most stallMax
      @(posedge pixel_clk_in);
      #10;
      mapWrEn     = 1'b0;
      columnReady = 1'b0;  // FIFO full while the ray is walked
      rayWord     = word;
      rayValid    = 1'b1;
      @(posedge pixel_clk_in);
      #10;
      rayValid = 1'b0;
      @(negedge pixel_clk_in);
      checkValue({name, " busy after accept"}, 1, rayBusy);
      @(posedge pixel_clk_in);
      #10;
      rayWord  = word ^ (RAY_WORD_WIDTH'({HCOUNT_WIDTH{1'b1}}) << HCOUNT_LSB);  // stray column
      rayValid = 1'b1;  // strobe while busy, must be dropped
      @(posedge pixel_clk_in);
      #10;
      rayValid = 1'b0;
      repeat (stall) begin
        @(negedge pixel_clk_in);
        checkValue({name, " columnValid under stall"}, 0, columnValid);
        checkValue({name, " busy under stall"}, 1, rayBusy);
      end
      @(posedge pixel_clk_in);
      #10;
      columnReady = 1'b1;
      waited = 0;
      do begin
        @(negedge pixel_clk_in);
        waited++;
      end while (!columnValid && waited < RESULT_WAIT);
      if (!columnValid) begin
        $display("%s: no column result within %0d cycles of columnReady", name, RESULT_WAIT);
        errorCount++;
      end else begin
        checkValue({name, " column"}, expCol, hcountOut);
        checkValue({name, " line height"}, expHeight, lineHeight);
        checkValue({name, " wall side"}, expSide, wallSideOut);
        checkValue({name, " cell"}, expCell, cellOut);
      end
      waited = 0;
      while (rayBusy && waited < RESULT_WAIT) begin  // drain, a second column would be counted
        @(negedge pixel_clk_in);
        waited++;
      end
      if (rayBusy) begin
        $display("%s: rayBusy stayed high after the column left", name);
        errorCount++;
      end
    end
    $display("test %s finished, %s", name, (errorCount == errsBefore) ? "ok" : "with errors");
  endtask

  initial begin
    bit ok;
    int rayNum;
    void'($urandom(89));  // seed once for the stall draws
    rst_in      = 1'b1;
    rayWord     = '0;
    rayValid    = 1'b0;
    mapWrEn     = 1'b0;
    mapWrAddr   = '0;
    mapWrData   = '0;
    columnReady = 1'b0;
    rayNum      = 0;
    loadStim(ok);
    if (!ok) begin
      $display("stim file tests/rayStim.txt is missing or malformed");
      errorCount++;
    end
    repeat (3) @(posedge pixel_clk_in);
    #10;
    rst_in = 1'b0;
    if (ok) begin
      watchdogCycles = rayCount * RESULT_WAIT + MAP_SIZE * MAP_SIZE + writeCount;
      fillRoom();
      foreach (lineQ[i]) begin
        if (lineQ[i].getc(0) == "W") begin
          applyWrite(lineQ[i]);
        end else begin
          castRay(lineQ[i], rayNum);
          rayNum++;
        end
      end
      checkValue("results vs accepted rays", rayCount, resultCount);
    end
    $display("rays %0d, map writes %0d, results %0d, errors %0d",
             rayCount, writeCount, resultCount, errorCount);
    if (errorCount == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== tests/rayStim.txt ====
# W <addr> <cell>: map write, addr = x + y*24, decimal
# R <ray word hex> <column> <line height> <wall side> <cell> <max stall cycles>
W 130 3
W 293 7
W 375 9
W 200 5
R 193011010000380058000880800 100 26 0 3 40
R 323120001000580038009000100 200 20 1 7 0
R 4B3010020000E800F8000801000 300 180 0 9 200
R 0510100040001000A8000000200 20 180 0 1 10
W 130 12
R 197011010000380058000880800 101 26 0 12 150
R 4FE300001800C800380180000C0 319 48 1 13 300
R 01E4000010008800A8020000080 7 120 1 5 5

// ==== filelist.f ====
logic/raycastPkg.sv
logic/rayIf.sv
logic/rayIntake.sv
logic/mapRam.sv
logic/fixedDivider.sv
logic/ddaStepper.sv
logic/columnResult.sv
logic/raycastCore.sv
tests/raycastCore_asserts.sv
tests/raycastTb.sv

// ==== runSim.sh ====
#!/bin/sh
# build the raycaster testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module raycastTb \
  -f filelist.f -o raycastSim || { echo "build failed"; exit 1; }
output=$(./obj_dir/raycastSim)
printf '%s\n' "$output"
printf '%s\n' "$output" | grep -qx "STATUS: PASS" && echo "run passed" \
  || { echo "run failed"; exit 1; }
